// File: src/arp_proto_pkg.sv
// arp protocol package: ethernet and arp wire-format constants and the parsed frame struct
`default_nettype none

package arp_proto_pkg;

    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip4_t;

    localparam logic [15:0] ETH_TYPE_ARP   = 16'h0806;
    localparam logic [15:0] ARP_HTYPE_ETH  = 16'h0001;
    localparam logic [15:0] ARP_PTYPE_IPV4 = 16'h0800;

    localparam mac_t MAC_BROADCAST = 48'hffff_ffff_ffff;

    // arp opcodes, inarp included
    typedef enum logic [15:0] {
        REQUEST       = 16'd1,
        REPLY         = 16'd2,
        INARP_REQUEST = 16'd8,
        INARP_REPLY   = 16'd9
    } arp_oper_e;

    // one frame as split by the upstream parser
    // oper stays a raw field since received frames may carry any opcode
    typedef struct packed {
        mac_t        eth_dest;
        mac_t        eth_src;
        logic [15:0] eth_type;
        logic [15:0] htype;
        logic [15:0] ptype;
        logic [15:0] oper;
        mac_t        sha;
        ip4_t        spa;
        mac_t        tha;
        ip4_t        tpa;
    } arp_frame_t;

endpackage

`default_nettype wire

// File: src/arp_lookup_pkg.sv
// arp lookup package: host lookup, cache access and configuration structs
`default_nettype none

package arp_lookup_pkg;

    import arp_proto_pkg::*;

    // static station configuration
    typedef struct packed {
        mac_t local_mac;
        ip4_t local_ip;
        ip4_t gateway_ip;
        ip4_t subnet_mask;
    } arp_cfg_t;

    // cache read side
    typedef struct packed {
        ip4_t ip;
    } cache_query_t;

    typedef struct packed {
        logic miss;
        mac_t mac;
    } cache_result_t;

    // cache write side, one learned sender pair
    typedef struct packed {
        ip4_t ip;
        mac_t mac;
    } cache_write_t;

    // answer to a host lookup
    // mac is only meaningful when error is low
    typedef struct packed {
        logic error;
        mac_t mac;
    } lookup_resp_t;

endpackage

`default_nettype wire

// File: src/arp_cache.sv
// arp cache: direct-mapped ip to mac table with a registered query port and one-cycle clear
`timescale 1ns/1ps
`default_nettype none

module arp_cache
    import arp_proto_pkg::*;
    import arp_lookup_pkg::*;
#(
    parameter int CACHE_ADDR_WIDTH = 6
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          clear_cache,

    input  wire logic          query_valid,
    input  wire cache_query_t  query,
    output logic               result_valid,
    output cache_result_t      result,

    input  wire logic          write_valid,
    input  wire cache_write_t  write
);

    localparam int DEPTH = 2 ** CACHE_ADDR_WIDTH;

    ip4_t                        ip_mem  [DEPTH];
    mac_t                        mac_mem [DEPTH];
    logic [DEPTH-1:0]            entry_valid;

    logic [CACHE_ADDR_WIDTH-1:0] query_idx;
    logic [CACHE_ADDR_WIDTH-1:0] write_idx;
    logic                        query_hit;

    // fold the address into the index range
    function automatic logic [CACHE_ADDR_WIDTH-1:0] cache_index(input ip4_t ip);
        logic [15:0] folded;
        folded = ip[31:16] ^ ip[15:0];
        return folded[CACHE_ADDR_WIDTH-1:0];
    endfunction

    assign query_idx = cache_index(query.ip);
    assign write_idx = cache_index(write.ip);
    assign query_hit = entry_valid[query_idx] && (ip_mem[query_idx] == query.ip);

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (write_valid) begin
            ip_mem[write_idx]  <= write.ip;
            mac_mem[write_idx] <= write.mac;
        end
    end

    // clear takes precedence over a write in the same cycle
    always_ff @(posedge clk) begin
        if (rst || clear_cache) begin
            entry_valid <= '0;
        end else if (write_valid) begin
            entry_valid[write_idx] <= 1'b1;
        end
    end

    // query reads the arrays before this cycle's write lands
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= query_valid;
        end
    end

    always_ff @(posedge clk) begin
        result.miss <= !query_hit;
        result.mac  <= mac_mem[query_idx];
    end

endmodule

`default_nettype wire

// File: src/arp_frame_responder.sv
// arp frame responder: validates received frames, learns the sender and builds reply frames
`timescale 1ns/1ps
`default_nettype none

module arp_frame_responder
    import arp_proto_pkg::*;
    import arp_lookup_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire arp_cfg_t     cfg,

    input  wire logic         rx_valid,
    output logic              rx_ready,
    input  wire arp_frame_t   rx_frame,

    output logic              cache_write_valid,
    output cache_write_t      cache_write,

    output logic              reply_valid,
    input  wire logic         reply_ready,
    output arp_frame_t        reply
);

    logic rx_accept;
    logic hdr_ok;
    logic answer_arp;
    logic answer_inarp;

    // a new frame only enters when the reply slot can move on
    assign rx_ready  = reply_ready;
    assign rx_accept = rx_valid && rx_ready;

    assign hdr_ok = (rx_frame.eth_type == ETH_TYPE_ARP) &&
                    (rx_frame.htype == ARP_HTYPE_ETH) &&
                    (rx_frame.ptype == ARP_PTYPE_IPV4);

    assign answer_arp   = (rx_frame.oper == REQUEST) && (rx_frame.tpa == cfg.local_ip);
    assign answer_inarp = (rx_frame.oper == INARP_REQUEST) && (rx_frame.tha == cfg.local_mac);

    always_ff @(posedge clk) begin
        if (rst) begin
            cache_write_valid <= 1'b0;
            reply_valid       <= 1'b0;
        end else begin
            cache_write_valid <= rx_accept && hdr_ok;
            if (rx_accept) begin
                reply_valid <= hdr_ok && (answer_arp || answer_inarp);
            end else if (reply_ready) begin
                reply_valid <= 1'b0;
            end
        end
    end

    // payload, captured with every accepted frame
    always_ff @(posedge clk) begin
        if (rx_accept) begin
            cache_write.ip  <= rx_frame.spa;
            cache_write.mac <= rx_frame.sha;

            reply.eth_dest <= rx_frame.eth_src;
            reply.eth_src  <= cfg.local_mac;
            reply.eth_type <= ETH_TYPE_ARP;
            reply.htype    <= ARP_HTYPE_ETH;
            reply.ptype    <= ARP_PTYPE_IPV4;
            reply.oper     <= answer_inarp ? INARP_REPLY : REPLY;
            reply.sha      <= cfg.local_mac;
            reply.spa      <= cfg.local_ip;
            reply.tha      <= rx_frame.sha;
            reply.tpa      <= rx_frame.spa;
        end
    end

endmodule

`default_nettype wire

// File: src/arp_resolver.sv
// arp resolver: host lookup FSM with subnet decision, cache queries and request retries
`timescale 1ns/1ps
`default_nettype none

module arp_resolver
    import arp_proto_pkg::*;
    import arp_lookup_pkg::*;
#(
    parameter int REQUEST_RETRY_COUNT    = 4,
    parameter int REQUEST_RETRY_INTERVAL = 50,
    parameter int REQUEST_TIMEOUT        = 200
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire arp_cfg_t      cfg,

    input  wire logic          req_valid,
    output logic               req_ready,
    input  wire ip4_t          req_ip,

    output logic               resp_valid,
    input  wire logic          resp_ready,
    output lookup_resp_t       resp,

    output logic               query_valid,
    output cache_query_t       query,
    input  wire logic          result_valid,
    input  wire cache_result_t result,

    output logic               request_valid,
    input  wire logic          request_ready,
    output arp_frame_t         request
);

    localparam int TIMER_MAX   = (REQUEST_TIMEOUT > REQUEST_RETRY_INTERVAL) ?
                                 REQUEST_TIMEOUT : REQUEST_RETRY_INTERVAL;
    localparam int TIMER_WIDTH = $clog2(TIMER_MAX + 1);
    localparam int CNT_WIDTH   = $clog2(REQUEST_RETRY_COUNT + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_QUERY,
        ST_RETRY
    } state_t;

    state_t                 state;
    ip4_t                   target_ip;
    logic [CNT_WIDTH-1:0]   retry_cnt;
    logic [TIMER_WIDTH-1:0] timer;

    logic is_broadcast;
    logic in_subnet;
    logic hit;

    // all host bits set
    assign is_broadcast = ~(req_ip | cfg.subnet_mask) == '0;
    assign in_subnet    = ((req_ip ^ cfg.local_ip) & cfg.subnet_mask) == '0;
    assign hit          = result_valid && !result.miss;

    assign query = '{ip: target_ip};

    assign request = '{
        eth_dest: MAC_BROADCAST,
        eth_src:  cfg.local_mac,
        eth_type: ETH_TYPE_ARP,
        htype:    ARP_HTYPE_ETH,
        ptype:    ARP_PTYPE_IPV4,
        oper:     REQUEST,
        sha:      cfg.local_mac,
        spa:      cfg.local_ip,
        tha:      '0,
        tpa:      target_ip
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            req_ready     <= 1'b0;
            resp_valid    <= 1'b0;
            query_valid   <= 1'b0;
            request_valid <= 1'b0;
            retry_cnt     <= '0;
            timer         <= '0;
        end else begin
            if (resp_valid && resp_ready) begin
                resp_valid <= 1'b0;
            end

            case (state)
                ST_IDLE: begin
                    if (req_valid && req_ready) begin
                        req_ready <= 1'b0;
                        if (is_broadcast) begin
                            resp_valid <= 1'b1;
                            resp       <= '{error: 1'b0, mac: MAC_BROADCAST};
                        end else begin
                            // off-subnet hosts are reached through the gateway
                            target_ip   <= in_subnet ? req_ip : cfg.gateway_ip;
                            query_valid <= 1'b1;
                            state       <= ST_QUERY;
                        end
                    end else begin
                        req_ready <= !resp_valid || resp_ready;
                    end
                end

                ST_QUERY: begin
                    if (hit) begin
                        resp_valid  <= 1'b1;
                        resp        <= '{error: 1'b0, mac: result.mac};
                        query_valid <= 1'b0;
                        state       <= ST_IDLE;
                    end else if (result_valid) begin
                        // first miss sends the first request frame
                        request_valid <= 1'b1;
                        retry_cnt     <= CNT_WIDTH'(REQUEST_RETRY_COUNT - 1);
                        state         <= ST_RETRY;
                    end
                end

                ST_RETRY: begin
                    // queries keep running, a learned reply shows up as a hit
                    if (hit && (!request_valid || request_ready)) begin
                        resp_valid    <= 1'b1;
                        resp          <= '{error: 1'b0, mac: result.mac};
                        request_valid <= 1'b0;
                        query_valid   <= 1'b0;
                        state         <= ST_IDLE;
                    end else if (request_valid) begin
                        if (request_ready) begin
                            request_valid <= 1'b0;
                            // last frame waits the long timeout
                            timer <= (retry_cnt != '0) ?
                                     TIMER_WIDTH'(REQUEST_RETRY_INTERVAL - 1) :
                                     TIMER_WIDTH'(REQUEST_TIMEOUT - 1);
                        end
                    end else if (timer != '0) begin
                        timer <= timer - 1'b1;
                    end else if (retry_cnt != '0) begin
                        request_valid <= 1'b1;
                        retry_cnt     <= retry_cnt - 1'b1;
                    end else begin
                        // out of retries
                        resp_valid  <= 1'b1;
                        resp        <= '{error: 1'b1, mac: '0};
                        query_valid <= 1'b0;
                        state       <= ST_IDLE;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/arp_tx_arbiter.sv
// tx arbiter: merges resolver requests and responder replies into one output register
`timescale 1ns/1ps
`default_nettype none

module arp_tx_arbiter
    import arp_proto_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,

    input  wire logic        request_valid,
    output logic             request_ready,
    input  wire arp_frame_t  request,

    input  wire logic        reply_valid,
    output logic             reply_ready,
    input  wire arp_frame_t  reply,

    output logic             tx_valid,
    input  wire logic        tx_ready,
    output arp_frame_t       tx_frame
);

    logic slot_free;

    // empty, or the held frame leaves this cycle
    assign slot_free     = !tx_valid || tx_ready;
    assign request_ready = slot_free;
    assign reply_ready   = slot_free && !request_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid <= 1'b0;
        end else if (request_valid && request_ready) begin
            tx_valid <= 1'b1;
        end else if (reply_valid && reply_ready) begin
            tx_valid <= 1'b1;
        end else if (tx_ready) begin
            tx_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (request_valid && request_ready) begin
            tx_frame <= request;
        end else if (reply_valid && reply_ready) begin
            tx_frame <= reply;
        end
    end

endmodule

`default_nettype wire

// File: src/arp_top.sv
// arp engine top: connects responder, resolver, cache and tx arbiter
`timescale 1ns/1ps
`default_nettype none

module arp_top
    import arp_proto_pkg::*;
    import arp_lookup_pkg::*;
#(
    parameter int CACHE_ADDR_WIDTH       = 6,
    parameter int REQUEST_RETRY_COUNT    = 4,
    parameter int REQUEST_RETRY_INTERVAL = 50,
    parameter int REQUEST_TIMEOUT        = 200
) (
    input  wire logic         clk,
    input  wire logic         rst,

    input  wire logic         rx_valid,
    output logic              rx_ready,
    input  wire arp_frame_t   rx_frame,

    output logic              tx_valid,
    input  wire logic         tx_ready,
    output arp_frame_t        tx_frame,

    input  wire logic         req_valid,
    output logic              req_ready,
    input  wire ip4_t         req_ip,
    output logic              resp_valid,
    input  wire logic         resp_ready,
    output lookup_resp_t      resp,

    input  wire arp_cfg_t     cfg,
    input  wire logic         clear_cache
);

    logic          cache_write_valid;
    cache_write_t  cache_write;
    logic          query_valid;
    cache_query_t  query;
    logic          result_valid;
    cache_result_t result;

    logic          reply_valid;
    logic          reply_ready;
    arp_frame_t    reply;
    logic          request_valid;
    logic          request_ready;
    arp_frame_t    request;

    arp_frame_responder i_arp_frame_responder (
        .clk               (clk),
        .rst               (rst),
        .cfg               (cfg),
        .rx_valid          (rx_valid),
        .rx_ready          (rx_ready),
        .rx_frame          (rx_frame),
        .cache_write_valid (cache_write_valid),
        .cache_write       (cache_write),
        .reply_valid       (reply_valid),
        .reply_ready       (reply_ready),
        .reply             (reply)
    );

    arp_resolver #(
        .REQUEST_RETRY_COUNT    (REQUEST_RETRY_COUNT),
        .REQUEST_RETRY_INTERVAL (REQUEST_RETRY_INTERVAL),
        .REQUEST_TIMEOUT        (REQUEST_TIMEOUT)
    ) i_arp_resolver (
        .clk           (clk),
        .rst           (rst),
        .cfg           (cfg),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_ip        (req_ip),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp          (resp),
        .query_valid   (query_valid),
        .query         (query),
        .result_valid  (result_valid),
        .result        (result),
        .request_valid (request_valid),
        .request_ready (request_ready),
        .request       (request)
    );

    arp_cache #(
        .CACHE_ADDR_WIDTH (CACHE_ADDR_WIDTH)
    ) i_arp_cache (
        .clk          (clk),
        .rst          (rst),
        .clear_cache  (clear_cache),
        .query_valid  (query_valid),
        .query        (query),
        .result_valid (result_valid),
        .result       (result),
        .write_valid  (cache_write_valid),
        .write        (cache_write)
    );

    // resolver requests win over replies
    arp_tx_arbiter i_arp_tx_arbiter (
        .clk           (clk),
        .rst           (rst),
        .request_valid (request_valid),
        .request_ready (request_ready),
        .request       (request),
        .reply_valid   (reply_valid),
        .reply_ready   (reply_ready),
        .reply         (reply),
        .tx_valid      (tx_valid),
        .tx_ready      (tx_ready),
        .tx_frame      (tx_frame)
    );

endmodule

`default_nettype wire

// File: tb/arp_top_sva.sv
// arp engine assertions: handshake hold, data stability and reset state of the outputs
`timescale 1ns/1ps
`default_nettype none

module arp_top_sva
    import arp_proto_pkg::*;
    import arp_lookup_pkg::*;
(
    input wire logic         clk,
    input wire logic         rst,
    input wire logic         tx_valid,
    input wire logic         tx_ready,
    input wire arp_frame_t   tx_frame,
    input wire logic         resp_valid,
    input wire logic         resp_ready,
    input wire lookup_resp_t resp
);

    // a stalled frame stays offered
    tx_valid_held: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid)
        else $error("tx_valid dropped while tx_ready was low");

    tx_frame_stable: assert property (@(posedge clk) disable iff (rst)
        tx_valid && !tx_ready |=> $stable(tx_frame))
        else $error("tx_frame changed while stalled");

    resp_valid_held: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid)
        else $error("resp_valid dropped while resp_ready was low");

    resp_stable: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> $stable(resp))
        else $error("resp changed while stalled");

    // outputs quiet right after a reset cycle
    reset_quiet: assert property (@(posedge clk)
        rst |=> !tx_valid && !resp_valid)
        else $error("tx_valid or resp_valid high after reset");

endmodule

bind arp_top arp_top_sva i_arp_top_sva (
    .clk        (clk),
    .rst        (rst),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .tx_frame   (tx_frame),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp       (resp)
);

`default_nettype wire

// File: tb/tb_arp_top.sv
// arp engine testbench with random frames and lookups checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_arp_top
    import arp_proto_pkg::*;
    import arp_lookup_pkg::*;
();

    localparam int CACHE_ADDR_WIDTH       = 6;
    localparam int REQUEST_RETRY_COUNT    = 3;
    localparam int REQUEST_RETRY_INTERVAL = 40;
    localparam int REQUEST_TIMEOUT        = 120;
    localparam int CACHE_DEPTH            = 2 ** CACHE_ADDR_WIDTH;
    localparam int NUM_TESTS              = 40;
    localparam int WATCHDOG_CYCLES        =
        NUM_TESTS * (REQUEST_TIMEOUT + 4 * REQUEST_RETRY_INTERVAL) * 2;
    localparam int DRAIN_LIMIT            = 200;

    logic         clk;
    logic         rst;
    logic         rx_valid;
    logic         rx_ready;
    arp_frame_t   rx_frame;
    logic         tx_valid;
    logic         tx_ready;
    arp_frame_t   tx_frame;
    logic         req_valid;
    logic         req_ready;
    ip4_t         req_ip;
    logic         resp_valid;
    logic         resp_ready;
    lookup_resp_t resp;
    arp_cfg_t     cfg;
    logic         clear_cache;

    // reference model state
    ip4_t        model_ip    [CACHE_DEPTH];
    mac_t        model_mac   [CACHE_DEPTH];
    bit          model_valid [CACHE_DEPTH];
    arp_frame_t  exp_frames  [$];
    int          requests_seen;
    int          errors;
    int          checks;
    ip4_t        learned;
    ip4_t        unknown;

    arp_top #(
        .CACHE_ADDR_WIDTH       (CACHE_ADDR_WIDTH),
        .REQUEST_RETRY_COUNT    (REQUEST_RETRY_COUNT),
        .REQUEST_RETRY_INTERVAL (REQUEST_RETRY_INTERVAL),
        .REQUEST_TIMEOUT        (REQUEST_TIMEOUT)
    ) i_arp_top (
        .clk         (clk),
        .rst         (rst),
        .rx_valid    (rx_valid),
        .rx_ready    (rx_ready),
        .rx_frame    (rx_frame),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready),
        .tx_frame    (tx_frame),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_ip      (req_ip),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp        (resp),
        .cfg         (cfg),
        .clear_cache (clear_cache)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // random back-pressure on both output sides
    initial begin
        tx_ready   = 1'b0;
        resp_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            tx_ready   = ($urandom % 4) != 0;
            resp_ready = ($urandom % 4) != 0;
        end
    end

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    function automatic int model_index(input ip4_t ip);
        logic [15:0] folded;
        folded = ip[31:16] ^ ip[15:0];
        return int'(folded) % CACHE_DEPTH;
    endfunction

    function automatic bit model_knows(input ip4_t ip);
        return model_valid[model_index(ip)] && (model_ip[model_index(ip)] == ip);
    endfunction

    function automatic bit in_subnet(input ip4_t ip);
        return ((ip ^ cfg.local_ip) & cfg.subnet_mask) == 32'd0;
    endfunction

    function automatic mac_t random_mac();
        return {16'($urandom), $urandom};
    endfunction

    // hosts .2 to .253 so never the gateway or the broadcast address
    function automatic ip4_t subnet_ip();
        return {cfg.local_ip[31:8], 8'(2 + $urandom % 252)};
    endfunction

    function automatic ip4_t offnet_ip();
        return {8'd172, 8'd16, 8'($urandom), 8'(1 + $urandom % 250)};
    endfunction

    function automatic arp_frame_t request_frame(input ip4_t target);
        return '{eth_dest: MAC_BROADCAST, eth_src: cfg.local_mac, eth_type: ETH_TYPE_ARP,
                 htype: ARP_HTYPE_ETH, ptype: ARP_PTYPE_IPV4, oper: REQUEST,
                 sha: cfg.local_mac, spa: cfg.local_ip, tha: '0, tpa: target};
    endfunction

    // reply frame from a host that gets learned but never answered
    function automatic arp_frame_t learn_frame(input ip4_t ip, input mac_t mac);
        return '{eth_dest: cfg.local_mac, eth_src: mac, eth_type: ETH_TYPE_ARP,
                 htype: ARP_HTYPE_ETH, ptype: ARP_PTYPE_IPV4, oper: REPLY,
                 sha: mac, spa: ip, tha: cfg.local_mac, tpa: cfg.local_ip};
    endfunction

    function automatic arp_frame_t random_frame(input int kind);
        arp_frame_t f;
        f.eth_dest = MAC_BROADCAST;
        f.eth_src  = random_mac();
        f.eth_type = ETH_TYPE_ARP;
        f.htype    = ARP_HTYPE_ETH;
        f.ptype    = ARP_PTYPE_IPV4;
        f.oper     = REQUEST;
        f.sha      = f.eth_src;
        f.spa      = ($urandom % 2 == 0) ? subnet_ip() : ip4_t'($urandom);
        f.tha      = '0;
        f.tpa      = cfg.local_ip;
        case (kind)
            1: f.tpa = cfg.local_ip ^ 32'(1 + $urandom % 255);
            2: f.htype = 16'd6;
            3: f.ptype = 16'h86dd;
            4: f.eth_type = 16'h0800;
            5: begin
                f.oper = INARP_REQUEST;
                f.tha  = cfg.local_mac;
                f.tpa  = '0;
            end
            6: begin
                f.oper = INARP_REQUEST;
                f.tha  = cfg.local_mac ^ 48'(1 + $urandom % 4095);
            end
            default: ;
        endcase
        return f;
    endfunction

    // learning and reply rules applied to one frame
    task automatic apply_model(input arp_frame_t f);
        bit         hdr_ok;
        bit         is_arp;
        bit         is_inarp;
        int         idx;
        arp_frame_t rep;
        hdr_ok   = (f.eth_type == 16'h0806) && (f.htype == 16'd1) && (f.ptype == 16'h0800);
        is_arp   = (f.oper == 16'd1) && (f.tpa == cfg.local_ip);
        is_inarp = (f.oper == 16'd8) && (f.tha == cfg.local_mac);
        if (hdr_ok) begin
            idx = model_index(f.spa);
            model_ip[idx]    = f.spa;
            model_mac[idx]   = f.sha;
            model_valid[idx] = 1'b1;
            if (is_arp || is_inarp) begin
                rep = '{eth_dest: f.eth_src, eth_src: cfg.local_mac,
                    eth_type: 16'h0806, htype: 16'd1, ptype: 16'h0800,
                    oper: is_inarp ? 16'd9 : 16'd2, sha: cfg.local_mac,
                    spa: cfg.local_ip, tha: f.sha, tpa: f.spa};
                exp_frames.push_back(rep);
            end
        end
    endtask

    task automatic send_frame(input arp_frame_t f);
        apply_model(f);
        rx_frame = f;
        rx_valid = 1'b1;
        do @(negedge clk); while (!rx_ready);
        @(posedge clk);
        #1;
        rx_valid = 1'b0;
    endtask

    // frame sink that matches by content against the expected set
    task automatic take_frame(input arp_frame_t f);
        int idx;
        idx = -1;
        foreach (exp_frames[i]) begin
            if (idx < 0 && exp_frames[i] == f) begin
                idx = i;
            end
        end
        checks++;
        assert (idx >= 0) else report_error($sformatf(
            "unexpected frame oper %0d tpa %h tha %h", f.oper, f.tpa, f.tha));
        if (idx >= 0) begin
            exp_frames.delete(idx);
        end
        if (f.oper == REQUEST) begin
            requests_seen++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst && tx_valid && tx_ready) begin
            take_frame(tx_frame);
        end
    end

    task automatic drain_frames();
        int waited;
        waited = 0;
        while (exp_frames.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        repeat (8) @(posedge clk);
        #1;
        checks++;
        assert (exp_frames.size() == 0) else begin
            report_error($sformatf("%0d expected frame(s) never sent", exp_frames.size()));
            exp_frames.delete();
        end
    endtask

    task automatic do_lookup(input ip4_t ip, output lookup_resp_t got);
        req_ip    = ip;
        req_valid = 1'b1;
        do @(negedge clk); while (!req_ready);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        do @(negedge clk); while (!(resp_valid && resp_ready));
        got = resp;
        @(posedge clk);
        #1;
    endtask

    task automatic check_lookup(input ip4_t ip, input bit inject);
        ip4_t         target;
        int           n_req;
        int           base;
        bit           exp_err;
        bit           inject_now;
        mac_t         exp_mac;
        mac_t         inj_mac;
        lookup_resp_t got;
        target     = in_subnet(ip) ? ip : cfg.gateway_ip;
        inj_mac    = random_mac();
        n_req      = 0;
        exp_err    = 1'b0;
        inject_now = 1'b0;
        if ((ip | cfg.subnet_mask) == '1) begin
            exp_mac = MAC_BROADCAST;
        end else if (model_knows(target)) begin
            exp_mac = model_mac[model_index(target)];
        end else if (inject) begin
            exp_mac    = inj_mac;
            n_req      = 1;
            inject_now = 1'b1;
        end else begin
            exp_err = 1'b1;
            exp_mac = '0;
            n_req   = REQUEST_RETRY_COUNT;
        end
        repeat (n_req) exp_frames.push_back(request_frame(target));
        base = requests_seen;
        fork
            do_lookup(ip, got);
            begin
                // answer right after the first request goes out
                if (inject_now) begin
                    wait (requests_seen > base);
                    @(posedge clk);
                    #1;
                    send_frame(learn_frame(target, inj_mac));
                end
            end
        join
        checks += 2;
        assert (got.error == exp_err) else report_error($sformatf(
            "lookup %h error flag %0b, expected %0b", ip, got.error, exp_err));
        assert (exp_err || got.mac == exp_mac) else report_error($sformatf(
            "lookup %h mac %h, expected %h", ip, got.mac, exp_mac));
        drain_frames();
    endtask

    initial begin
        void'($urandom(59115));
        rst           = 1'b1;
        rx_valid      = 1'b0;
        rx_frame      = '0;
        req_valid     = 1'b0;
        req_ip        = '0;
        clear_cache   = 1'b0;
        errors        = 0;
        checks        = 0;
        requests_seen = 0;
        foreach (model_valid[i]) model_valid[i] = 1'b0;
        cfg.local_mac   = random_mac();
        cfg.local_ip    = {8'd10, 8'($urandom), 8'($urandom), 8'd20};
        cfg.subnet_mask = 32'hffff_ff00;
        cfg.gateway_ip  = {cfg.local_ip[31:8], 8'd1};
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        // arp and inarp replies and bad headers
        repeat (24) send_frame(random_frame($urandom % 7));
        drain_frames();

        // subnet and global broadcast
        check_lookup(cfg.local_ip | ~cfg.subnet_mask, 1'b0);
        check_lookup('1, 1'b0);

        repeat (6) begin
            learned = subnet_ip();
            send_frame(learn_frame(learned, random_mac()));
            drain_frames();
            check_lookup(learned, 1'b0);
        end
        send_frame(learn_frame(cfg.gateway_ip, random_mac()));
        drain_frames();
        repeat (2) check_lookup(offnet_ip(), 1'b0);

        // one miss runs out of retries and two get answered
        for (int i = 0; i < 3; i++) begin
            do unknown = subnet_ip(); while (model_knows(unknown));
            check_lookup(unknown, i > 0);
        end

        clear_cache = 1'b1;
        @(posedge clk);
        #1;
        clear_cache = 1'b0;
        foreach (model_valid[i]) model_valid[i] = 1'b0;
        check_lookup(learned, 1'b0);

        $display("errors: %0d of %0d checks failed", errors, checks);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not complete",
                 WATCHDOG_CYCLES);
        $display("errors: %0d of %0d checks failed", errors, checks);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
src/arp_proto_pkg.sv
src/arp_lookup_pkg.sv
src/arp_cache.sv
src/arp_frame_responder.sv
src/arp_resolver.sv
src/arp_tx_arbiter.sv
src/arp_top.sv
tb/arp_top_sva.sv
tb/tb_arp_top.sv

// File: run.sh
#!/bin/sh
# build and run the arp engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_arp_top -f files.f

output=$(./obj_dir/Vtb_arp_top)
echo "$output"

if echo "$output" | grep -q '^\*\* PASS \*\*$'; then
    echo "run.sh: simulation passed"
else
    echo "run.sh: simulation failed"
    exit 1
fi
